/* InstDecoder/InstDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module InstDecoder #(
    parameter DATA_WIDTH = 32,
    parameter PC_WIDTH   = 32,
    parameter REG_WIDTH  = 5)
(
    input  logic                  i_Clock,
    input  logic                  i_rstN,
    input  logic                  i_InstValid,      // One instruction per strobe
    input  Types::InstWord        i_Inst,
    input  logic [PC_WIDTH-1:0]   i_PC,
    input  logic [DATA_WIDTH-1:0] i_RdDataA,        // Register file port A
    input  logic [DATA_WIDTH-1:0] i_RdDataB,        // Register file port B
    input  Types::ExResult        i_Bypass,         // Live execute result

    output logic [REG_WIDTH-1:0]  o_RdAddrA,
    output logic [REG_WIDTH-1:0]  o_RdAddrB,
    output Types::DecodedEx       o_Decoded);

    logic [31:0]           instBits;                // Raw word for U and J fields
    Types::AluOp           aluOp;
    Types::OperandASel     aSel;
    Types::OperandBSel     bSel;
    logic [DATA_WIDTH-1:0] imm;
    logic                  we;
    logic                  hitA;
    logic                  hitB;
    Types::DecodedEx       decNext;

    // funct3 to operation, alt is instruction bit 30
    function automatic Types::AluOp DecodeFunct(input logic [2:0] funct3,
                                                input logic       alt,
                                                input logic       isReg);
        Types::AluOp op;
        case (funct3)
            3'b000:  op = (alt && isReg) ? Types::AluSub : Types::AluAdd;
            3'b001:  op = Types::AluSll;
            3'b010:  op = Types::AluSlt;
            3'b011:  op = Types::AluSltu;
            3'b100:  op = Types::AluXor;
            3'b101:  op = alt ? Types::AluSra : Types::AluSrl;
            3'b110:  op = Types::AluOr;
            default: op = Types::AluAnd;
        endcase
        return op;
    endfunction

    assign instBits  = i_Inst;
    assign o_RdAddrA = i_Inst.rType.rs1;
    assign o_RdAddrB = i_Inst.rType.rs2;            // Immediate bits on I-type, unused

    // ------------------------------------------------
    // Opcode decode and immediate build
    // ------------------------------------------------

    always_comb begin
        aluOp = Types::AluAdd;
        aSel  = Types::ASelReg;
        bSel  = Types::BSelReg;
        imm   = '0;
        we    = 1'b0;                               // Unknown opcode, no write
        case (i_Inst.rType.opcode)
            Types::OpcodeReg: begin
                aluOp = DecodeFunct(i_Inst.rType.funct3, i_Inst.rType.funct7[5], 1'b1);
                we    = 1'b1;
            end
            Types::OpcodeImm: begin
                // imm12[10] selects SRAI over SRLI
                aluOp = DecodeFunct(i_Inst.iType.funct3, i_Inst.iType.imm12[10], 1'b0);
                bSel  = Types::BSelImm;
                imm   = {{(DATA_WIDTH-12){i_Inst.iType.imm12[11]}}, i_Inst.iType.imm12};
                we    = 1'b1;
            end
            Types::OpcodeLui: begin
                aSel = Types::ASelZero;             // 0 + upper immediate
                bSel = Types::BSelImm;
                imm  = DATA_WIDTH'({instBits[31:12], 12'b0});
                we   = 1'b1;
            end
            Types::OpcodeAuipc: begin
                aSel = Types::ASelPc;
                bSel = Types::BSelImm;
                imm  = DATA_WIDTH'({instBits[31:12], 12'b0});
                we   = 1'b1;
            end
            Types::OpcodeJal: begin
                aSel = Types::ASelPc;               // Link value PC + 4
                bSel = Types::BSelFour;
                imm  = {{(DATA_WIDTH-20){instBits[31]}}, instBits[19:12], instBits[20],
                        instBits[30:21], 1'b0};
                we   = 1'b1;
            end
            default: ;
        endcase
    end

    // Forward from execute when it writes a nonzero source
    assign hitA = i_Bypass.valid && i_Bypass.we && (i_Bypass.rd != '0) &&
                  (i_Bypass.rd == i_Inst.rType.rs1);
    assign hitB = i_Bypass.valid && i_Bypass.we && (i_Bypass.rd != '0) &&
                  (i_Bypass.rd == i_Inst.rType.rs2);

    always_comb begin
        decNext.valid = 1'b1;
        decNext.pc    = i_PC;
        decNext.dataA = hitA ? i_Bypass.result : i_RdDataA;
        decNext.dataB = hitB ? i_Bypass.result : i_RdDataB;
        decNext.imm   = imm;
        decNext.aluOp = aluOp;
        decNext.aSel  = aSel;
        decNext.bSel  = bSel;
        decNext.rd    = i_Inst.rType.rd;
        decNext.we    = we;
    end

    // Decode to execute register, payload held while idle
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN)
            o_Decoded <= '0;
        else if (i_InstValid)
            o_Decoded <= decNext;
        else
            o_Decoded.valid <= 1'b0;
    end

endmodule

`default_nettype wire

/* StageEX/StageEX.sv */
`timescale 1ns/1ps
`default_nettype none

module StageEX #(
    parameter DATA_WIDTH = 32,
    parameter PC_WIDTH   = 32)
(
    input  logic [DATA_WIDTH-1:0] i_InstIMM,            // Decoded immediate
    input  logic [DATA_WIDTH-1:0] i_DataA,              // rs1 data, forwarded
    input  logic [DATA_WIDTH-1:0] i_DataB,              // rs2 data, forwarded
    input  logic [PC_WIDTH-1:0]   i_PC,                 // Instruction address
    input  logic [1:0]            i_OperandASel,
    input  logic [1:0]            i_OperandBSel,
    input  Types::AluOp           i_AluControl,

    output logic [DATA_WIDTH-1:0] o_Result);

    logic [DATA_WIDTH-1:0] operandA;
    logic [DATA_WIDTH-1:0] operandB;

    // ------------------------------------------------
    // Operand A, register, PC or zero
    // ------------------------------------------------

    always_comb begin
        case (i_OperandASel)
            Types::ASelReg:  operandA = i_DataA;
            Types::ASelPc:   operandA = DATA_WIDTH'(i_PC);     // Zero extended
            Types::ASelZero: operandA = '0;
            default:         operandA = '0;                    // Unused code
        endcase
    end

    // ------------------------------------------------
    // Operand B, register, immediate or four
    // ------------------------------------------------

    always_comb begin
        case (i_OperandBSel)
            Types::BSelReg:  operandB = i_DataB;
            Types::BSelImm:  operandB = i_InstIMM;
            Types::BSelFour: operandB = DATA_WIDTH'(4);         // Link offset
            default:         operandB = '0;
        endcase
    end

    // Calculation
    ALU #(
        .WIDTH (DATA_WIDTH))
    Alu (
        .i_Op       (i_AluControl),
        .i_OperandA (operandA),
        .i_OperandB (operandB),
        .o_Result   (o_Result));

endmodule

`default_nettype wire

/* common/Types.sv */
`default_nettype none

package Types;

    // ------------------------------------------------
    // Widths fixed for the pipeline structs
    // ------------------------------------------------

    localparam int DataWidth = 32;          // Integer datapath
    localparam int PcWidth   = 32;          // Instruction address
    localparam int RegWidth  = 5;           // x0..x31

    // RV32I major opcodes handled here
    localparam logic [6:0] OpcodeReg   = 7'b0110011;    // R-type ALU
    localparam logic [6:0] OpcodeImm   = 7'b0010011;    // I-type ALU
    localparam logic [6:0] OpcodeLui   = 7'b0110111;
    localparam logic [6:0] OpcodeAuipc = 7'b0010111;
    localparam logic [6:0] OpcodeJal   = 7'b1101111;

    // ALU operations, ordered after funct3
    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluSll,
        AluSlt,                             // Signed compare
        AluSltu,                            // Unsigned compare
        AluXor,
        AluSrl,
        AluSra,
        AluOr,
        AluAnd
    } AluOp;

    // Operand A source
    typedef enum logic [1:0] {
        ASelReg  = 2'd0,
        ASelPc   = 2'd1,
        ASelZero = 2'd2                     // LUI path
    } OperandASel;

    // Operand B source
    typedef enum logic [1:0] {
        BSelReg  = 2'd0,
        BSelImm  = 2'd1,
        BSelFour = 2'd2                     // JAL link
    } OperandBSel;

    // ------------------------------------------------
    // Instruction word, register or immediate view
    // ------------------------------------------------

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } InstR;

    typedef struct packed {
        logic [11:0] imm12;                 // Same bits as funct7 + rs2
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } InstI;

    typedef union packed {
        InstR rType;
        InstI iType;
    } InstWord;

    // Decode to execute register contents
    typedef struct packed {
        logic                 valid;
        logic [PcWidth-1:0]   pc;
        logic [DataWidth-1:0] dataA;        // rs1 after forwarding
        logic [DataWidth-1:0] dataB;        // rs2 after forwarding
        logic [DataWidth-1:0] imm;          // I, U or J immediate
        AluOp                 aluOp;
        OperandASel           aSel;
        OperandBSel           bSel;
        logic [RegWidth-1:0]  rd;
        logic                 we;
    } DecodedEx;

    // Execute result, also the write port and the bypass
    typedef struct packed {
        logic                 valid;
        logic [RegWidth-1:0]  rd;
        logic                 we;
        logic [DataWidth-1:0] result;
    } ExResult;

endpackage

`default_nettype wire

/* hdl/ALU.sv */
`timescale 1ns/1ps
`default_nettype none

module ALU #(
    parameter WIDTH = 32)
(
    input  Types::AluOp      i_Op,
    input  logic [WIDTH-1:0] i_OperandA,
    input  logic [WIDTH-1:0] i_OperandB,

    output logic [WIDTH-1:0] o_Result);

    logic [4:0] shamt;                              // RV32I shift amount
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = i_OperandB[4:0];          // Upper bits ignored
    assign lessSigned   = $signed(i_OperandA) < $signed(i_OperandB);
    assign lessUnsigned = i_OperandA < i_OperandB;

    // ------------------------------------------------
    // Operation select
    // ------------------------------------------------

    always_comb begin
        case (i_Op)
            Types::AluAdd:  o_Result = i_OperandA + i_OperandB;
            Types::AluSub:  o_Result = i_OperandA - i_OperandB;
            Types::AluSll:  o_Result = i_OperandA << shamt;
            Types::AluSlt:  o_Result = {{(WIDTH-1){1'b0}}, lessSigned};      // 0 or 1
            Types::AluSltu: o_Result = {{(WIDTH-1){1'b0}}, lessUnsigned};
            Types::AluXor:  o_Result = i_OperandA ^ i_OperandB;
            Types::AluSrl:  o_Result = i_OperandA >> shamt;                  // Zero fill
            Types::AluSra:  o_Result = $unsigned($signed(i_OperandA) >>> shamt);
            Types::AluOr:   o_Result = i_OperandA | i_OperandB;
            Types::AluAnd:  o_Result = i_OperandA & i_OperandB;
            default:        o_Result = '0;                                   // Unused codes
        endcase
    end

endmodule

`default_nettype wire

/* hdl/ExecCore.sv */
`timescale 1ns/1ps
`default_nettype none

module ExecCore #(
    parameter DATA_WIDTH = 32,
    parameter PC_WIDTH   = 32,
    parameter REG_WIDTH  = 5)
(
    input  logic                  i_Clock,
    input  logic                  i_rstN,
    input  logic                  i_InstValid,      // One-cycle strobe
    input  Types::InstWord        i_Inst,
    input  logic [PC_WIDTH-1:0]   i_PC,

    output logic                  o_ResultValid,    // Two edges after strobe
    output logic [REG_WIDTH-1:0]  o_ResultReg,
    output logic [DATA_WIDTH-1:0] o_Result);

    // Struct fields are sized by the package constants
    if (DATA_WIDTH != Types::DataWidth || PC_WIDTH != Types::PcWidth ||
        REG_WIDTH != Types::RegWidth) begin : g_WidthCheck
        $error("ExecCore parameters differ from the Types package widths");
    end

    logic [REG_WIDTH-1:0]  rdAddrA;
    logic [REG_WIDTH-1:0]  rdAddrB;
    logic [DATA_WIDTH-1:0] rdDataA;
    logic [DATA_WIDTH-1:0] rdDataB;
    Types::DecodedEx       decoded;                 // Decode to execute register
    logic [DATA_WIDTH-1:0] exOut;                   // ALU result, combinational
    Types::ExResult        exLive;                  // Bypass and write port
    Types::ExResult        resultQ;                 // Output register

    // ------------------------------------------------
    // Decode, register read, forwarding
    // ------------------------------------------------

    InstDecoder #(
        .DATA_WIDTH (DATA_WIDTH),
        .PC_WIDTH   (PC_WIDTH),
        .REG_WIDTH  (REG_WIDTH))
    Decoder (
        .i_Clock     (i_Clock),
        .i_rstN      (i_rstN),
        .i_InstValid (i_InstValid),
        .i_Inst      (i_Inst),
        .i_PC        (i_PC),
        .i_RdDataA   (rdDataA),
        .i_RdDataB   (rdDataB),
        .i_Bypass    (exLive),
        .o_RdAddrA   (rdAddrA),
        .o_RdAddrB   (rdAddrB),
        .o_Decoded   (decoded));

    // ------------------------------------------------
    // Execute
    // ------------------------------------------------

    StageEX #(
        .DATA_WIDTH (DATA_WIDTH),
        .PC_WIDTH   (PC_WIDTH))
    Execute (
        .i_InstIMM     (decoded.imm),
        .i_DataA       (decoded.dataA),
        .i_DataB       (decoded.dataB),
        .i_PC          (decoded.pc),
        .i_OperandASel (decoded.aSel),
        .i_OperandBSel (decoded.bSel),
        .i_AluControl  (decoded.aluOp),
        .o_Result      (exOut));

    // Live result, aligned with the decoded register
    always_comb begin
        exLive.valid  = decoded.valid;
        exLive.rd     = decoded.rd;
        exLive.we     = decoded.we;
        exLive.result = exOut;
    end

    // Result register, edge N+1
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN)
            resultQ <= '0;
        else
            resultQ <= exLive;
    end

    // Written on the same edge as the result register
    RegisterFile #(
        .DATA_WIDTH (DATA_WIDTH),
        .REG_WIDTH  (REG_WIDTH))
    RegFile (
        .i_Clock   (i_Clock),
        .i_rstN    (i_rstN),
        .i_Write   (exLive),
        .i_RdAddrA (rdAddrA),
        .i_RdAddrB (rdAddrB),
        .o_RdDataA (rdDataA),
        .o_RdDataB (rdDataB));

    assign o_ResultValid = resultQ.valid;
    assign o_ResultReg   = resultQ.rd;              // x0 writes still shown
    assign o_Result      = resultQ.result;

endmodule

`default_nettype wire

/* hdl/RegisterFile.sv */
`timescale 1ns/1ps
`default_nettype none

module RegisterFile #(
    parameter DATA_WIDTH = 32,
    parameter REG_WIDTH  = 5)
(
    input  logic                  i_Clock,
    input  logic                  i_rstN,
    input  Types::ExResult        i_Write,          // Execute result, same edge
    input  logic [REG_WIDTH-1:0]  i_RdAddrA,
    input  logic [REG_WIDTH-1:0]  i_RdAddrB,

    output logic [DATA_WIDTH-1:0] o_RdDataA,
    output logic [DATA_WIDTH-1:0] o_RdDataB);

    localparam int NumRegs = 2**REG_WIDTH;

    logic [DATA_WIDTH-1:0] regs [NumRegs];
    logic                  doWrite;

    // x0 never written, stays zero from reset
    assign doWrite = i_Write.valid && i_Write.we && (i_Write.rd != '0);

    // ------------------------------------------------
    // Write port
    // ------------------------------------------------

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int n = 0; n < NumRegs; n++)
                regs[n] <= '0;                      // Whole file cleared
        end
        else if (doWrite) begin
            regs[i_Write.rd] <= i_Write.result;
        end
    end

    // Asynchronous reads
    assign o_RdDataA = regs[i_RdAddrA];
    assign o_RdDataB = regs[i_RdAddrB];

endmodule

`default_nettype wire

/* list.f */
common/Types.sv
hdl/ALU.sv
StageEX/StageEX.sv
InstDecoder/InstDecoder.sv
hdl/RegisterFile.sv
hdl/ExecCore.sv
test/ExecCore_chk.sv
test/ExecCore_tb.sv

/* test/ExecCore_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module ExecCore_chk (
    input logic                        i_Clock,
    input logic                        i_rstN,
    input logic                        i_InstValid,
    input Types::InstWord              i_Inst,
    input logic                        i_ResultValid,
    input logic [Types::RegWidth-1:0]  i_ResultReg,
    input logic [Types::DataWidth-1:0] i_Result);

    // --------------------------------------------------
    // Fixed two-edge latency, destination carried along
    // --------------------------------------------------

    property pLatency;
        @(posedge i_Clock) disable iff (!i_rstN)
            i_InstValid |-> ##2 (i_ResultValid &&
                                 i_ResultReg == $past(i_Inst.rType.rd, 2));
    endproperty

    // No unknown value leaves with the strobe
    property pResultKnown;
        @(posedge i_Clock) disable iff (!i_rstN)
            i_ResultValid |-> !$isunknown(i_Result);
    endproperty

    property pQuietInReset;
        @(posedge i_Clock) !i_rstN |-> !i_ResultValid;
    endproperty

    aLatency: assert property (pLatency)
        else $error("result strobe not two cycles after instruction");
    aResultKnown: assert property (pResultKnown)
        else $error("result holds X while valid");
    aQuietReset: assert property (pQuietInReset)
        else $error("result valid during reset");

endmodule

bind ExecCore ExecCore_chk u_ExecCoreChk (
    .i_Clock       (i_Clock),
    .i_rstN        (i_rstN),
    .i_InstValid   (i_InstValid),
    .i_Inst        (i_Inst),
    .i_ResultValid (o_ResultValid),
    .i_ResultReg   (o_ResultReg),
    .i_Result      (o_Result));

`default_nettype wire

/* test/ExecCore_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ExecCore_tb;

    localparam int MaxVec        = 64;              // Lines the data file may hold
    localparam int TimeoutCycles = 20;              // Longest wait for output
    localparam int Latency       = 2;               // Strobe to result register

    logic                           clock;
    logic                           rstN;
    logic                           instValid;
    Types::InstWord                 inst;
    logic [Types::PcWidth-1:0]      pc;
    logic                           resultValid;
    logic [Types::RegWidth-1:0]     resultReg;
    logic [Types::DataWidth-1:0]    result;

    logic [31:0] vecMem [0:4*MaxVec-1];             // inst, pc, rd, result per line
    logic [31:0] expRegQ [$];
    logic [31:0] expResQ [$];
    int          issueQ [$];                        // Cycle of each strobe
    int          idQ [$];                           // Line number, for error lines
    int          cycleCnt   = 0;
    int          errorCount = 0;
    int          checkCount = 0;

    ExecCore #(
        .DATA_WIDTH (Types::DataWidth),
        .PC_WIDTH   (Types::PcWidth),
        .REG_WIDTH  (Types::RegWidth))
    u_ExecCore (
        .i_Clock       (clock),
        .i_rstN        (rstN),
        .i_InstValid   (instValid),
        .i_Inst        (inst),
        .i_PC          (pc),
        .o_ResultValid (resultValid),
        .o_ResultReg   (resultReg),
        .o_Result      (result));

    // --------------------------------------------------
    // Clock and cycle count
    // --------------------------------------------------

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;                  // 10 ns period
    end

    always @(posedge clock)
        cycleCnt <= cycleCnt + 1;

    task automatic CheckValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("mismatch %s expected %h actual %h", testName, expected, actual);
        end
    endtask

    // Drain the scoreboard, bounded
    task automatic WaitForResults();
        int waited;
        waited = 0;
        while (expResQ.size() != 0 && waited < TimeoutCycles) begin
            @(posedge clock);
            waited++;
        end
        if (expResQ.size() != 0) begin
            errorCount++;
            $display("no result arrived within %0d cycles, %0d instructions still outstanding",
                     TimeoutCycles, expResQ.size());
        end
    endtask

    // --------------------------------------------------
    // Output monitor, sampled mid-cycle
    // --------------------------------------------------

    always @(negedge clock) begin : monitor
        int          id;
        int          issued;
        logic [31:0] expReg;
        logic [31:0] expRes;
        if (rstN && resultValid) begin
            if (expResQ.size() == 0) begin
                errorCount++;
                $display("result for x%0d arrived with no instruction outstanding", resultReg);
            end
            else begin
                id     = idQ.pop_front();
                issued = issueQ.pop_front();
                expReg = expRegQ.pop_front();
                expRes = expResQ.pop_front();
                CheckValue($sformatf("inst%0d rd", id), expReg, 32'(resultReg));
                CheckValue($sformatf("inst%0d result", id), expRes, result);
                CheckValue($sformatf("inst%0d latency", id), 32'(issued + Latency),
                           32'(cycleCnt));      // In order, two edges after strobe
            end
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    initial begin
        int numVec;
        int gap;
        void'($urandom(91534));                     // Single seed for the run
        rstN      = 1'b0;
        instValid = 1'b0;
        inst      = '0;
        pc        = '0;
        $readmemh("test/exec_input.txt", vecMem);
        numVec = 0;
        while (numVec < MaxVec && !$isunknown(vecMem[4*numVec]))
            numVec++;
        if (numVec == 0) begin
            errorCount++;
            $display("no stimulus lines could be read from the data file");
        end

        repeat (16) @(posedge clock);               // Reset held 16 cycles
        #1 rstN = 1'b1;

        for (int v = 0; v < numVec; v++) begin
            @(posedge clock);
            #1;
            instValid = 1'b1;
            inst      = vecMem[4*v];
            pc        = vecMem[4*v+1];
            idQ.push_back(v);
            issueQ.push_back(cycleCnt);
            expRegQ.push_back(vecMem[4*v+2]);
            expResQ.push_back(vecMem[4*v+3]);
            gap = $urandom_range(2, 0);             // Zero gap means back-to-back
            for (int g = 0; g < gap; g++) begin
                @(posedge clock);
                #1 instValid = 1'b0;
            end
        end
        @(posedge clock);
        #1 instValid = 1'b0;

        WaitForResults();

        $display("errors %0d, checks %0d", errorCount, checkCount);
        if (errorCount == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* test/exec_input.txt */
// Columns: instruction word, PC, expected destination register, expected result
// Register file starts all zero, PC steps by 4 from 0x100
00500093 00000100 00000001 00000005 // addi x1, x0, 5
FFD00113 00000104 00000002 FFFFFFFD // addi x2, x0, -3
002081B3 00000108 00000003 00000002 // add  x3, x1, x2
40208233 0000010C 00000004 00000008 // sub  x4, x1, x2
003092B3 00000110 00000005 00000014 // sll  x5, x1, x3
00112333 00000114 00000006 00000001 // slt  x6, x2, x1
001133B3 00000118 00000007 00000000 // sltu x7, x2, x1
0020C433 0000011C 00000008 FFFFFFF8 // xor  x8, x1, x2
003154B3 00000120 00000009 3FFFFFFF // srl  x9, x2, x3
40315533 00000124 0000000A FFFFFFFF // sra  x10, x2, x3
0030E5B3 00000128 0000000B 00000007 // or   x11, x1, x3
0040F633 0000012C 0000000C 00000000 // and  x12, x1, x4
00012693 00000130 0000000D 00000001 // slti x13, x2, 0
FFF0B713 00000134 0000000E 00000001 // sltiu x14, x1, -1
0F00C793 00000138 0000000F 000000F5 // xori x15, x1, 0xF0
40115813 0000013C 00000010 FFFFFFFE // srai x16, x2, 1
01C15893 00000140 00000011 0000000F // srli x17, x2, 28
00409913 00000144 00000012 00000050 // slli x18, x1, 4
00396993 00000148 00000013 00000053 // ori  x19, x18, 3
00F9FA13 0000014C 00000014 00000003 // andi x20, x19, 0xF
12345AB7 00000150 00000015 12345000 // lui  x21, 0x12345
00001B17 00000154 00000016 00001154 // auipc x22, 0x1
008000EF 00000158 00000001 0000015C // jal  x1, +8
00108013 0000015C 00000000 0000015D // addi x0, x1, 1
00700B93 00000160 00000017 00000007 // addi x23, x0, 7
00100C33 00000164 00000018 0000015C // add  x24, x0, x1
018B8CB3 00000168 00000019 00000163 // add  x25, x23, x24
41900D33 0000016C 0000001A FFFFFE9D // sub  x26, x0, x25
